// ==== all.f ====
design/lda_pkg.sv
design/lda_cmd_fifo.sv
design/lda_datapath.sv
design/lda_control.sv
design/lda_top.sv
tb/lda_assert.sv
tb/lda_tb.sv

// ==== design/lda_cmd_fifo.sv ====
module lda_cmd_fifo import lda_pkg::*; #(
  parameter int CMD_DEPTH = 4
) (
  input  logic      i_clk,
  input  logic      i_reset,
  // write side, source holds a credit for every write
  input  logic      i_wr,
  input  line_cmd_t i_wr_cmd,
  // pop from control
  input  logic      i_pop,
  output line_cmd_t o_head,
  output logic      o_not_empty,
  // one pulse per popped command
  output logic      o_cmd_credit
);

  localparam int PTR_W = $clog2(CMD_DEPTH);
  localparam int CNT_W = $clog2(CMD_DEPTH + 1);

  // command storage
  line_cmd_t mem [CMD_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // occupancy, never above CMD_DEPTH thanks to credits
  logic [CNT_W-1:0] count;
  logic             do_pop;

  // wrap at CMD_DEPTH, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign o_not_empty  = (count != '0);
  assign do_pop       = i_pop && o_not_empty;
  // credit goes back in the cycle of the pop
  assign o_cmd_credit = do_pop;
  assign o_head       = mem[rd_ptr];

  // storage, no full check needed
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      mem[wr_ptr] <= i_wr_cmd;
    end
  end

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // write and pop together leave occupancy as is
      case ({i_wr, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== design/lda_control.sv ====
module lda_control #(
  parameter int PIX_CREDITS = 4
) (
  input  logic i_clk,
  input  logic i_reset,
  // from the queue
  input  logic i_not_empty,
  // from the datapath
  input  logic i_keep_drawing,
  // returned by the sink, one per consumed pixel
  input  logic i_pix_credit,
  // pop, also the datapath load strobe
  output logic o_pop,
  // advance the datapath one pixel
  output logic o_step,
  output logic o_pix_valid
);

  localparam int CNT_W = $clog2(PIX_CREDITS + 1);

  typedef enum logic {
    S_IDLE,
    S_DRAW
  } state_t;

  state_t state;
  state_t state_nxt;

  // pixels the sink can still take
  logic [CNT_W-1:0] pix_credits;
  logic             has_credit;

  assign has_credit = (pix_credits != '0);

  // pop as soon as a command waits
  assign o_pop       = (state == S_IDLE) && i_not_empty;
  // the pixel is presented only with credit in hand
  assign o_pix_valid = (state == S_DRAW) && has_credit;
  // last pixel needs no step
  assign o_step      = o_pix_valid && i_keep_drawing;

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (i_not_empty) begin
          state_nxt = S_DRAW;
        end
      end
      S_DRAW: begin
        // endpoint sent, next command may be popped
        if (o_pix_valid && !i_keep_drawing) begin
          state_nxt = S_IDLE;
        end
      end
      default: begin
        state_nxt = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // up/down credit counter
  // a return and a spend in one cycle cancel
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      pix_credits <= CNT_W'(PIX_CREDITS);
    end else begin
      case ({i_pix_credit, o_pix_valid})
        2'b10:   pix_credits <= pix_credits + 1'b1;
        2'b01:   pix_credits <= pix_credits - 1'b1;
        default: pix_credits <= pix_credits;
      endcase
    end
  end

endmodule

// ==== design/lda_datapath.sv ====
module lda_datapath import lda_pkg::*; (
  input  logic      i_clk,
  input  logic      i_reset,
  // head command from the queue
  input  line_cmd_t i_cmd,
  // from control
  input  logic      i_ld_initial,
  input  logic      i_step,
  // current pixel
  output coord_x_t  o_x,
  output coord_y_t  o_y,
  output color_t    o_color,
  // to control
  output logic      o_keep_drawing
);

  // endpoints widened to the signed working width
  acc_t ax0;
  acc_t ax1;
  acc_t ay0;
  acc_t ay1;
  // absolute deltas of the incoming command
  acc_t abs_dx;
  acc_t abs_dy;
  logic x_fwd;
  logic y_fwd;
  logic w_steep;

  // registered line state
  // major axis is x, or y when steep
  logic steep;
  logic major_neg;
  acc_t d_major;
  acc_t d_minor;
  acc_t major_step;
  acc_t minor_step;
  acc_t endpoint;
  acc_t err;
  acc_t major;
  acc_t minor;
  color_t color;

  // error update terms
  acc_t err_diff;
  logic err_neg;

  // octant setup from the head command
  always_comb begin
    ax0     = {1'b0, i_cmd.x0};
    ax1     = {1'b0, i_cmd.x1};
    ay0     = {2'b00, i_cmd.y0};
    ay1     = {2'b00, i_cmd.y1};
    x_fwd   = (ax1 >= ax0);
    y_fwd   = (ay1 >= ay0);
    abs_dx  = x_fwd ? (ax1 - ax0) : (ax0 - ax1);
    abs_dy  = y_fwd ? (ay1 - ay0) : (ay0 - ay1);
    // steep lines walk along y
    w_steep = (abs_dy > abs_dx);
  end

  // error minus minor delta, sign decides the minor step
  assign err_diff = err - d_minor;
  assign err_neg  = (err_diff < acc_t'(0));

  // still short of the endpoint in the walking direction
  assign o_keep_drawing = major_neg ? (major > endpoint) : (major < endpoint);

  // swap back for steep lines
  assign o_x     = steep ? minor[8:0] : major[8:0];
  assign o_y     = steep ? major[7:0] : minor[7:0];
  assign o_color = color;

  // octant registers, fixed for the whole line
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      steep      <= 1'b0;
      major_neg  <= 1'b0;
      d_major    <= '0;
      d_minor    <= '0;
      major_step <= '0;
      minor_step <= '0;
      endpoint   <= '0;
    end else if (i_ld_initial) begin
      steep      <= w_steep;
      major_neg  <= w_steep ? !y_fwd : !x_fwd;
      d_major    <= w_steep ? abs_dy : abs_dx;
      d_minor    <= w_steep ? abs_dx : abs_dy;
      major_step <= (w_steep ? y_fwd : x_fwd) ? acc_t'(1) : acc_t'(-1);
      minor_step <= (w_steep ? x_fwd : y_fwd) ? acc_t'(1) : acc_t'(-1);
      endpoint   <= w_steep ? ay1 : ax1;
    end
  end

  // error term and coordinates, updated together on a step
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      err   <= '0;
      major <= '0;
      minor <= '0;
    end else if (i_ld_initial) begin
      // start at half the major delta
      err   <= (w_steep ? abs_dy : abs_dx) >>> 1;
      major <= w_steep ? ay0 : ax0;
      minor <= w_steep ? ax0 : ay0;
    end else if (i_step) begin
      major <= major + major_step;
      if (err_neg) begin
        minor <= minor + minor_step;
        err   <= err_diff + d_major;
      end else begin
        err   <= err_diff;
      end
    end
  end

  // color rides along with the line
  always_ff @(posedge i_clk) begin
    if (i_ld_initial) begin
      color <= i_cmd.color;
    end
  end

endmodule

// ==== design/lda_pkg.sv ====
package lda_pkg;

  // screen coordinates, 320x240 style raster
  // x needs 9 bits
  typedef logic [8:0] coord_x_t;
  // y needs 8 bits
  typedef logic [7:0] coord_y_t;

  // 3-bit rgb color
  typedef logic [2:0] color_t;

  // signed working width inside the datapath
  // one bit wider than x so deltas, error and steps fit
  typedef logic signed [9:0] acc_t;

  // one line command as queued by the source
  // both endpoints are drawn
  typedef struct packed {
    coord_x_t x0;
    coord_x_t x1;
    coord_y_t y0;
    coord_y_t y1;
    color_t   color;
  } line_cmd_t;

  // one pixel toward the frame-buffer writer
  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
    color_t   color;
  } pixel_t;

endpackage

// ==== design/lda_top.sv ====
module lda_top import lda_pkg::*; #(
  parameter int CMD_DEPTH   = 4,
  parameter int PIX_CREDITS = 4
) (
  input  logic      i_clk,
  input  logic      i_reset,
  // command side, credit based
  input  logic      i_cmd_valid,
  input  line_cmd_t i_cmd,
  output logic      o_cmd_credit,
  // pixel side, credit based
  output logic      o_pix_valid,
  output pixel_t    o_pix,
  input  logic      i_pix_credit
);

  // queue to control and datapath
  line_cmd_t head_cmd;
  logic      not_empty;
  // control strobes
  logic      pop;
  logic      step;
  // datapath results
  logic      keep_drawing;
  coord_x_t  pix_x;
  coord_y_t  pix_y;
  color_t    pix_color;

  // pixel bus from datapath coordinates and loaded color
  assign o_pix = '{x: pix_x, y: pix_y, color: pix_color};

  lda_cmd_fifo #(
    .CMD_DEPTH (CMD_DEPTH)
  ) u_fifo (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_wr         (i_cmd_valid),
    .i_wr_cmd     (i_cmd),
    .i_pop        (pop),
    .o_head       (head_cmd),
    .o_not_empty  (not_empty),
    .o_cmd_credit (o_cmd_credit)
  );

  lda_control #(
    .PIX_CREDITS (PIX_CREDITS)
  ) u_control (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_not_empty    (not_empty),
    .i_keep_drawing (keep_drawing),
    .i_pix_credit   (i_pix_credit),
    .o_pop          (pop),
    .o_step         (step),
    .o_pix_valid    (o_pix_valid)
  );

  // pop doubles as the load strobe
  lda_datapath u_datapath (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_cmd          (head_cmd),
    .i_ld_initial   (pop),
    .i_step         (step),
    .o_x            (pix_x),
    .o_y            (pix_y),
    .o_color        (pix_color),
    .o_keep_drawing (keep_drawing)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the line-drawing engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module lda_tb -f all.f -o lda_sim

# a $fatal in the testbench or a failed assertion gives a nonzero status
./obj_dir/lda_sim

// ==== tb/lda_assert.sv ====
module lda_assert #(
  parameter int CMD_DEPTH   = 4,
  parameter int PIX_CREDITS = 4
) (
  input logic i_clk,
  input logic i_reset,
  input logic i_cmd_valid,
  input logic i_cmd_credit,
  input logic i_pop,
  input logic i_not_empty,
  input logic i_pix_valid,
  input logic i_pix_credit
);

  timeunit 1ns;
  timeprecision 100ps;

  // shadow of the engine pixel credit counter
  int   credits;
  // shadow of the queue occupancy
  int   occupancy;
  // queue has held a command since reset
  logic seen_cmd;

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      credits   <= PIX_CREDITS;
      occupancy <= 0;
      seen_cmd  <= 1'b0;
    end else begin
      credits   <= credits + int'(i_pix_credit) - int'(i_pix_valid);
      occupancy <= occupancy + int'(i_cmd_valid) - int'(i_cmd_credit);
      if (i_not_empty) begin
        seen_cmd <= 1'b1;
      end
    end
  end

  a_pix_needs_credit: assert property (@(posedge i_clk) disable iff (i_reset)
    i_pix_valid |-> (credits > 0))
    else $error("pixel valid with zero pixel credit");

  // a credit only ever returns a command the queue really held
  a_credit_needs_pop: assert property (@(posedge i_clk) disable iff (i_reset)
    i_cmd_credit |-> (i_pop && occupancy > 0))
    else $error("command credit pulse without a pop");

  a_occupancy_bound: assert property (@(posedge i_clk) disable iff (i_reset)
    occupancy <= CMD_DEPTH)
    else $error("command queue occupancy above its depth");

  // nothing to draw before the first command lands
  a_no_early_pixel: assert property (@(posedge i_clk) disable iff (i_reset)
    !seen_cmd |-> !i_pix_valid)
    else $error("pixel valid before any command reached the queue");

endmodule

bind lda_top lda_assert #(
  .CMD_DEPTH   (CMD_DEPTH),
  .PIX_CREDITS (PIX_CREDITS)
) u_assert (
  .i_clk        (i_clk),
  .i_reset      (i_reset),
  .i_cmd_valid  (i_cmd_valid),
  .i_cmd_credit (o_cmd_credit),
  .i_pop        (pop),
  .i_not_empty  (not_empty),
  .i_pix_valid  (o_pix_valid),
  .i_pix_credit (i_pix_credit)
);

// ==== tb/lda_tb.sv ====
module lda_tb import lda_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // odd depth exercises pointer wrap
  localparam int CMD_DEPTH   = 3;
  localparam int PIX_CREDITS = 3;
  localparam int NUM_CMDS    = 40;
  localparam logic [31:0] SEED = 32'h1211;

  // one expected pixel plus line bookkeeping
  typedef struct packed {
    pixel_t pix;
    logic   last;
    pixel_t end_pix;
  } exp_t;

  logic      clk = 1'b0;
  logic      reset;
  logic      cmd_valid;
  line_cmd_t cmd;
  logic      cmd_credit;
  logic      pix_valid;
  pixel_t    pix;
  logic      pix_credit;

  line_cmd_t   cmds [NUM_CMDS];
  exp_t        exp_q [$];
  // pixel count of each sent line, in command order
  int          len_q [$];
  // cycle at which each pixel credit goes back
  int          due_q [$];
  logic [31:0] src_rng = SEED;
  logic [31:0] sink_rng = ~SEED;
  int          limit = 0;
  int          cycles = 0;
  // source side
  int          sent = 0;
  int          gap = 0;
  int          cmd_credits = CMD_DEPTH;
  int          credit_pulses = 0;
  // sink side
  int          sink_credits = PIX_CREDITS;
  int          sink_cycle = 0;
  int          last_due = 0;
  int          line_pix = 0;
  int          pix_total = 0;
  int          exp_total = 0;

  lda_top #(
    .CMD_DEPTH   (CMD_DEPTH),
    .PIX_CREDITS (PIX_CREDITS)
  ) dut0 (
    .i_clk        (clk),
    .i_reset      (reset),
    .i_cmd_valid  (cmd_valid),
    .i_cmd        (cmd),
    .o_cmd_credit (cmd_credit),
    .o_pix_valid  (pix_valid),
    .o_pix        (pix),
    .i_pix_credit (pix_credit)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // uniform-ish value in 0..n-1 from the upper lcg bits
  task automatic draw(inout logic [31:0] state, input int n, output int v);
    state = lcg(state);
    v = int'(state[31:16]) % n;
  endtask

  function automatic int major_delta(input line_cmd_t c);
    int dx;
    int dy;
    dx = int'(c.x1) - int'(c.x0);
    dy = int'(c.y1) - int'(c.y0);
    dx = (dx < 0) ? -dx : dx;
    dy = (dy < 0) ? -dy : dy;
    return (dy > dx) ? dy : dx;
  endfunction

  // move by d toward either side, staying on screen
  function automatic int offset_coord(input int v, input int d, input int down, input int max_v);
    if (down != 0 && v >= d) begin
      return v - d;
    end else if (v + d <= max_v) begin
      return v + d;
    end
    return v - d;
  endfunction

  task automatic fail_plain(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_pixel(input string name, input pixel_t act, input pixel_t exp);
    if (act !== exp) begin
      $display("Fail %0t %s got x=%0d y=%0d c=%0d expected x=%0d y=%0d c=%0d", $time,
               name, act.x, act.y, act.color, exp.x, exp.y, exp.color);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic check_count(input string name, input acc_t act, input acc_t exp);
    if (act !== exp) begin
      $display("Fail %0t %s got %0d expected %0d", $time, name, act, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  // textbook integer bresenham, walking from start to end point
  task automatic model_line(input line_cmd_t c);
    int   dx;
    int   dy;
    int   smaj;
    int   smin;
    int   dmaj;
    int   dmin;
    int   maj;
    int   mnr;
    int   err;
    int   n;
    logic steep;
    exp_t e;
    dx = int'(c.x1) - int'(c.x0);
    dy = int'(c.y1) - int'(c.y0);
    steep = ((dy < 0 ? -dy : dy) > (dx < 0 ? -dx : dx));
    smaj = steep ? ((dy < 0) ? -1 : 1) : ((dx < 0) ? -1 : 1);
    smin = steep ? ((dx < 0) ? -1 : 1) : ((dy < 0) ? -1 : 1);
    dmaj = steep ? (dy < 0 ? -dy : dy) : (dx < 0 ? -dx : dx);
    dmin = steep ? (dx < 0 ? -dx : dx) : (dy < 0 ? -dy : dy);
    maj  = steep ? int'(c.y0) : int'(c.x0);
    mnr  = steep ? int'(c.x0) : int'(c.y0);
    err  = dmaj / 2;
    e.end_pix = '{x: c.x1, y: c.y1, color: c.color};
    for (n = 0; n <= dmaj; n++) begin
      e.pix.x = coord_x_t'(steep ? mnr : maj);
      e.pix.y = coord_y_t'(steep ? maj : mnr);
      e.pix.color = c.color;
      e.last = (n == dmaj);
      exp_q.push_back(e);
      err = err - dmin;
      if (err < 0) begin
        mnr = mnr + smin;
        err = err + dmaj;
      end
      maj = maj + smaj;
    end
  endtask

  // one pixel seen by the sink
  task automatic take_pixel(input pixel_t p);
    exp_t e;
    int   delay;
    int   due;
    if (sink_credits == 0) begin
      fail_plain("pixel presented while the sink had granted no credit");
    end
    sink_credits--;
    if (exp_q.size() == 0) begin
      fail_plain("pixel arrived that no command asked for");
    end
    e = exp_q.pop_front();
    check_pixel("o_pix", p, e.pix);
    line_pix++;
    pix_total++;
    if (e.last) begin
      // line closes on its own end point
      check_pixel("o_pix end point", p, e.end_pix);
    end
    // credit comes back after a random delay, one per cycle at most
    draw(sink_rng, 4, delay);
    due = sink_cycle + delay;
    if (due <= last_due) begin
      due = last_due + 1;
    end
    last_due = due;
    due_q.push_back(due);
  endtask

  // random command source, limited by command credits
  always @(posedge clk) begin
    if (reset) begin
      cmd_valid <= 1'b0;
    end else begin
      if (cmd_credit) begin
        cmd_credits++;
        credit_pulses++;
        // a pop closes the line drawn before it
        if (credit_pulses > 1) begin
          check_count("pixels per line", acc_t'(line_pix), acc_t'(len_q.pop_front()));
        end
        line_pix = 0;
      end
      cmd_valid <= 1'b0;
      if (gap > 0) begin
        gap--;
      end else if (sent < NUM_CMDS && cmd_credits > 0) begin
        cmd <= cmds[sent];
        cmd_valid <= 1'b1;
        cmd_credits--;
        model_line(cmds[sent]);
        len_q.push_back(major_delta(cmds[sent]) + 1);
        sent++;
        draw(src_rng, 3, gap);
      end
    end
  end

  // pixel sink with credit return
  always @(posedge clk) begin
    if (reset) begin
      pix_credit <= 1'b0;
    end else begin
      sink_cycle++;
      if (pix_credit) begin
        sink_credits++;
      end
      if (pix_valid) begin
        take_pixel(pix);
      end
      if (due_q.size() != 0 && due_q[0] <= sink_cycle) begin
        pix_credit <= 1'b1;
        void'(due_q.pop_front());
      end else begin
        pix_credit <= 1'b0;
      end
    end
  end

  // run limit from the line lengths
  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles with %0d pixels still expected", cycles,
               exp_q.size());
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  initial begin
    int i;
    int kind;
    int x0;
    int x1;
    int y0;
    int y1;
    int d;
    int sgn;
    int r;
    int c;
    reset      = 1'b1;
    cmd_valid  = 1'b0;
    cmd        = '0;
    pix_credit = 1'b0;
    // first eight commands cover every kind once
    for (i = 0; i < NUM_CMDS; i++) begin
      if (i < 8) begin
        kind = i;
      end else begin
        draw(src_rng, 8, kind);
      end
      draw(src_rng, 320, x0);
      draw(src_rng, 240, y0);
      x1 = x0;
      y1 = y0;
      case (kind)
        // 0 is a single point
        0: begin
        end
        1: draw(src_rng, 320, x1);
        2: draw(src_rng, 240, y1);
        3: begin
          // 45 degrees, any direction
          draw(src_rng, 16, d);
          draw(src_rng, 2, sgn);
          x1 = offset_coord(x0, d, sgn, 319);
          draw(src_rng, 2, sgn);
          y1 = offset_coord(y0, d, sgn, 239);
        end
        4: begin
          draw(src_rng, 320, x1);
          draw(src_rng, 240, y1);
        end
        default: begin
          // short line, xor keeps it inside a 16-pixel block
          draw(src_rng, 16, r);
          x1 = x0 ^ r;
          draw(src_rng, 16, r);
          y1 = y0 ^ r;
        end
      endcase
      draw(src_rng, 8, c);
      cmds[i] = '{x0: coord_x_t'(x0), x1: coord_x_t'(x1), y0: coord_y_t'(y0),
                  y1: coord_y_t'(y1), color: color_t'(c)};
      limit += (major_delta(cmds[i]) + 1) * 4;
      exp_total += major_delta(cmds[i]) + 1;
    end
    limit += 200;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    while (pix_total < exp_total) begin
      @(negedge clk);
    end
    // idle stretch catches any extra pixel
    repeat (20) @(negedge clk);
    check_count("o_cmd_credit pulses", acc_t'(credit_pulses), acc_t'(NUM_CMDS));
    // last line has no later pop to close it
    check_count("pixels per line", acc_t'(line_pix), acc_t'(len_q.pop_front()));
    check_count("pixel total", acc_t'(pix_total), acc_t'(exp_total));
    check_count("pixels outstanding", acc_t'(exp_q.size()), acc_t'(0));
    $display("=== PASS ===");
    $finish;
  end

endmodule
